//--- include/conv_dma_settings.svh
`ifndef CONV_DMA_SETTINGS_SVH
`define CONV_DMA_SETTINGS_SVH

// data beat geometry
`define CONV_DATA_W 512
`define CONV_BEAT_BYTES 64

// pages split at 4 KiB boundaries
`define CONV_PAGE_BYTES 4096
`define CONV_BEATS_PER_PAGE 64

// pages allowed in flight per direction
`define CONV_START_CREDS 6

// output fifo holds 1 << CONV_FIFO_LOG_DEPTH beats
`define CONV_FIFO_LOG_DEPTH 3

`define CONV_ADDR_W 64

// configuration registers, written in this order
`define CONV_REG_SRC 32'h00
`define CONV_REG_DST 32'h08
`define CONV_REG_SIZE 32'h10
`define CONV_REG_START 32'h18

// status registers, read only
`define CONV_REG_STATE 32'h20
`define CONV_REG_PAGES 32'h28
`define CONV_REG_RD_BEATS 32'h30
`define CONV_REG_WR_BEATS 32'h38

`endif

//--- rtl/conv_dma_pkg.sv
`include "conv_dma_settings.svh"

package conv_dma_pkg;

    // configuration sequence, one state per accepted register write
    typedef enum logic [2:0] {
        IDLE,
        HAVE_SRC,
        HAVE_DST,
        HAVE_SIZE,
        RUN
    } run_state_e;

    // register offsets seen on the control port
    typedef enum logic [31:0] {
        REG_SRC      = `CONV_REG_SRC,
        REG_DST      = `CONV_REG_DST,
        REG_SIZE     = `CONV_REG_SIZE,
        REG_START    = `CONV_REG_START,
        REG_STATE    = `CONV_REG_STATE,
        REG_PAGES    = `CONV_REG_PAGES,
        REG_RD_BEATS = `CONV_REG_RD_BEATS,
        REG_WR_BEATS = `CONV_REG_WR_BEATS
    } csr_reg_e;

    typedef struct packed {
        logic [31:0] total_beats;
        logic [31:0] pages;
        logic [31:0] last_beats;
    } plan_t;

    typedef struct packed {
        logic [`CONV_ADDR_W-1:0] src;
        logic [`CONV_ADDR_W-1:0] dst;
    } cfg_t;

    // one burst on an address channel, len is beats minus one
    typedef struct packed {
        logic                    valid;
        logic [`CONV_ADDR_W-1:0] addr;
        logic [7:0]              len;
        logic [2:0]              size;
    } burst_req_t;

    typedef struct packed {
        logic        valid;
        logic        is_write;
        logic [31:0] addr;
        logic [63:0] data;
    } reg_req_t;

endpackage

//--- rtl/csr_decode.sv
`timescale 1ns/1ps

module csr_decode
    import conv_dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  reg_req_t    reg_req,
    input  logic        done,
    input  plan_t       plan,
    input  logic [31:0] rd_beats,
    input  logic [31:0] wr_beats,
    output cfg_t        cfg,
    output logic [31:0] img_size,
    output logic        run,
    output logic        resp_valid,
    output logic [63:0] resp_data
);

    run_state_e state_q;
    csr_reg_e   req_reg;
    csr_reg_e   exp_reg;
    logic       wr_hit;
    logic       rd_req;
    logic       status_sel;
    logic [63:0] status_word;

    assign req_reg = csr_reg_e'(reg_req.addr);
    assign rd_req  = reg_req.valid && !reg_req.is_write;

    // the one offset the current state will accept
    always_comb begin
        case (state_q)
            HAVE_SRC:  exp_reg = REG_DST;
            HAVE_DST:  exp_reg = REG_SIZE;
            HAVE_SIZE: exp_reg = REG_START;
            default:   exp_reg = REG_SRC;
        endcase
    end

    assign wr_hit = reg_req.valid && reg_req.is_write && state_q != RUN && req_reg == exp_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else if (state_q == RUN) begin
            if (done) begin
                state_q <= IDLE;
            end
        end else if (wr_hit) begin
            case (state_q)
                IDLE:     state_q <= HAVE_SRC;
                HAVE_SRC: state_q <= HAVE_DST;
                HAVE_DST: state_q <= HAVE_SIZE;
                default:  state_q <= RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit && state_q == IDLE) begin
            cfg.src <= reg_req.data;
        end
        if (wr_hit && state_q == HAVE_SRC) begin
            cfg.dst <= reg_req.data;
        end
        if (wr_hit && state_q == HAVE_DST) begin
            img_size <= reg_req.data[31:0];
        end
    end

    assign run = state_q == RUN;

    // status mux, other offsets get no answer
    always_comb begin
        status_sel  = 1'b1;
        status_word = '0;
        case (req_reg)
            REG_STATE:    status_word = 64'(state_q);
            REG_PAGES:    status_word = 64'(plan.pages);
            REG_RD_BEATS: status_word = 64'(rd_beats);
            REG_WR_BEATS: status_word = 64'(wr_beats);
            default:      status_sel  = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= rd_req && status_sel;
        end
    end

    always_ff @(posedge clk) begin
        resp_data <= status_word;
    end

endmodule

//--- rtl/page_planner.sv
`timescale 1ns/1ps
`include "conv_dma_settings.svh"

module page_planner
    import conv_dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] img_size,
    output plan_t       plan
);

    localparam logic [31:0] BPP = 32'(`CONV_BEATS_PER_PAGE);

    logic [31:0] total_q;
    logic [31:0] pages_q;
    logic [31:0] rem_q;
    logic [31:0] last_q;

    // stage 1: beats per row times rows
    // stage 2: whole pages and the partial tail
    // stage 3: an empty tail means the last page is full
    always_ff @(posedge clk) begin
        if (rst) begin
            total_q <= '0;
            pages_q <= '0;
            rem_q   <= '0;
            last_q  <= BPP;
        end else begin
            total_q <= (img_size / 32'(`CONV_BEAT_BYTES)) * img_size;
            pages_q <= (total_q + BPP - 32'd1) / BPP;
            rem_q   <= total_q % BPP;
            last_q  <= (rem_q == '0) ? BPP : rem_q;
        end
    end

    assign plan.total_beats = total_q;
    assign plan.pages       = pages_q;
    assign plan.last_beats  = last_q;

endmodule

//--- rtl/page_req_gen.sv
`timescale 1ns/1ps
`include "conv_dma_settings.svh"

module page_req_gen
    import conv_dma_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    done,
    input  logic [`CONV_ADDR_W-1:0] base,
    input  plan_t                   plan,
    input  logic                    page_done,
    input  logic                    ready,
    output burst_req_t              req
);

    localparam int CRED_W     = $clog2(`CONV_START_CREDS + 1);
    localparam int PAGE_SHIFT = $clog2(`CONV_PAGE_BYTES);
    localparam logic [CRED_W-1:0] START_CREDS = CRED_W'(`CONV_START_CREDS);

    logic [31:0]       pages_q;
    logic [CRED_W-1:0] creds_q;
    logic              issue;
    logic              last_page;
    logic [31:0]       len_beats;

    assign last_page = pages_q == plan.pages - 32'd1;
    assign len_beats = last_page ? plan.last_beats : 32'(`CONV_BEATS_PER_PAGE);

    // page k lives at base + k pages
    assign req.valid = run && pages_q != plan.pages && creds_q != '0;
    assign req.addr  = base + (`CONV_ADDR_W'(pages_q) << PAGE_SHIFT);
    assign req.len   = 8'(len_beats - 32'd1);
    assign req.size  = 3'($clog2(`CONV_BEAT_BYTES));

    assign issue = req.valid && ready;

    always_ff @(posedge clk) begin
        if (rst || done) begin
            pages_q <= '0;
            creds_q <= START_CREDS;
        end else begin
            if (issue) begin
                pages_q <= pages_q + 32'd1;
            end
            // spend and return in one cycle cancel out
            case ({issue, page_done})
                2'b10:   creds_q <= creds_q - 1'b1;
                2'b01:   creds_q <= creds_q + 1'b1;
                default: creds_q <= creds_q;
            endcase
        end
    end

    // a page can only complete after its request went out
    a_creds_bounded: assert property (@(posedge clk) disable iff (rst)
        creds_q <= START_CREDS);

endmodule

//--- rtl/stream_buffer.sv
`timescale 1ns/1ps
`include "conv_dma_settings.svh"

module stream_buffer
    import conv_dma_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    done,
    input  plan_t                   plan,
    input  logic [`CONV_DATA_W-1:0] rdata,
    input  logic                    rvalid,
    input  logic                    rlast,
    input  logic                    wready,
    output logic                    rready,
    output logic [`CONV_DATA_W-1:0] wdata,
    output logic                    wvalid,
    output logic                    wlast,
    output logic                    rd_page_done,
    output logic                    wr_page_done,
    output logic [31:0]             rd_beats,
    output logic [31:0]             wr_beats
);

    localparam int DEPTH = 1 << `CONV_FIFO_LOG_DEPTH;
    localparam int PW    = `CONV_FIFO_LOG_DEPTH + 1;

    logic                    ready_q;
    logic                    beat_valid_q;
    logic [`CONV_DATA_W-1:0] beat_data_q;
    logic [`CONV_DATA_W-1:0] mem [DEPTH];
    logic [PW-1:0]           wr_ptr_q;
    logic [PW-1:0]           rd_ptr_q;
    logic [PW-1:0]           count;
    logic                    rd_accept;
    logic                    push;
    logic                    pop;
    logic [31:0]             wr_in_page_q;
    logic [31:0]             wr_pages_q;
    logic [31:0]             page_len;

    assign rready       = run && ready_q;
    assign rd_accept    = rvalid && rready;
    assign rd_page_done = rd_accept && rlast;

    // pointers carry one extra wrap bit, so the difference is the fill level
    assign count  = wr_ptr_q - rd_ptr_q;
    assign push   = beat_valid_q;
    assign wvalid = count != '0;
    assign pop    = wvalid && wready;
    assign wdata  = mem[rd_ptr_q[PW-2:0]];

    assign page_len     = (wr_pages_q == plan.pages - 32'd1) ? plan.last_beats
                                                             : 32'(`CONV_BEATS_PER_PAGE);
    assign wlast        = wr_in_page_q == page_len - 32'd1;
    assign wr_page_done = pop && wlast;

    // throttle reads two beats before the fifo starts to fill
    always_ff @(posedge clk) begin
        if (rst || done) begin
            ready_q      <= 1'b0;
            beat_valid_q <= 1'b0;
        end else begin
            ready_q      <= wready && count < PW'(2);
            beat_valid_q <= rd_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            beat_data_q <= rdata;
        end
        if (push) begin
            mem[wr_ptr_q[PW-2:0]] <= beat_data_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || done) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            rd_beats     <= '0;
            wr_beats     <= '0;
            wr_in_page_q <= '0;
            wr_pages_q   <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_accept) begin
                rd_beats <= rd_beats + 32'd1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                wr_beats <= wr_beats + 32'd1;
                if (wlast) begin
                    wr_in_page_q <= '0;
                    wr_pages_q   <= wr_pages_q + 32'd1;
                end else begin
                    wr_in_page_q <= wr_in_page_q + 32'd1;
                end
            end
        end
    end

    // the read side stops early enough that in-flight beats always fit
    a_fifo_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push && !pop |-> count < PW'(DEPTH));

    a_wdata_hold: assert property (@(posedge clk) disable iff (rst || done)
        wvalid && !wready |=> $stable(wdata));

endmodule

//--- rtl/conv_dma_top.sv
`timescale 1ns/1ps
`include "conv_dma_settings.svh"

module conv_dma_top
    import conv_dma_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    output burst_req_t                 ar_req,
    input  logic                       arready,
    input  logic [`CONV_DATA_W-1:0]    rdata,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic                       rready,
    output burst_req_t                 aw_req,
    input  logic                       awready,
    output logic [`CONV_DATA_W-1:0]    wdata,
    output logic [`CONV_BEAT_BYTES-1:0] wstrb,
    output logic                       wlast,
    output logic                       wvalid,
    input  logic                       wready,
    input  logic                       bvalid,
    input  logic [1:0]                 bresp,
    output logic                       bready,
    input  reg_req_t                   reg_req,
    output logic                       resp_valid,
    output logic [63:0]                resp_data
);

    cfg_t        cfg;
    plan_t       plan;
    logic [31:0] img_size;
    logic        run;
    logic        done;
    logic        rd_page_done;
    logic        wr_page_done;
    logic [31:0] rd_beats;
    logic [31:0] wr_beats;

    // finished once every planned beat has left on the write channel
    assign done = run && wr_beats == plan.total_beats;

    assign wstrb  = '1;
    assign bready = 1'b1;

    csr_decode csr_decode_i (
        .clk        (clk),
        .rst        (rst),
        .reg_req    (reg_req),
        .done       (done),
        .plan       (plan),
        .rd_beats   (rd_beats),
        .wr_beats   (wr_beats),
        .cfg        (cfg),
        .img_size   (img_size),
        .run        (run),
        .resp_valid (resp_valid),
        .resp_data  (resp_data)
    );

    page_planner page_planner_i (
        .clk      (clk),
        .rst      (rst),
        .img_size (img_size),
        .plan     (plan)
    );

    page_req_gen rd_req_gen (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .done      (done),
        .base      (cfg.src),
        .plan      (plan),
        .page_done (rd_page_done),
        .ready     (arready),
        .req       (ar_req)
    );

    page_req_gen wr_req_gen (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .done      (done),
        .base      (cfg.dst),
        .plan      (plan),
        .page_done (wr_page_done),
        .ready     (awready),
        .req       (aw_req)
    );

    stream_buffer stream_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .done         (done),
        .plan         (plan),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .rlast        (rlast),
        .wready       (wready),
        .rready       (rready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wlast        (wlast),
        .rd_page_done (rd_page_done),
        .wr_page_done (wr_page_done),
        .rd_beats     (rd_beats),
        .wr_beats     (wr_beats)
    );

endmodule

//--- dv/tb_conv_dma.sv
`timescale 1ns/1ps
`include "conv_dma_settings.svh"

module tb_conv_dma
    import conv_dma_pkg::*;
;

    localparam int BPP = `CONV_BEATS_PER_PAGE;

    logic                        clk;
    logic                        rst;
    burst_req_t                  ar_req;
    logic                        arready;
    logic [`CONV_DATA_W-1:0]     rdata;
    logic                        rlast;
    logic                        rvalid;
    logic                        rready;
    burst_req_t                  aw_req;
    logic                        awready;
    logic [`CONV_DATA_W-1:0]     wdata;
    logic [`CONV_BEAT_BYTES-1:0] wstrb;
    logic                        wlast;
    logic                        wvalid;
    logic                        wready;
    logic                        bvalid;
    logic [1:0]                  bresp;
    logic                        bready;
    reg_req_t                    reg_req;
    logic                        resp_valid;
    logic [63:0]                 resp_data;

    // memory model and scoreboard state
    logic [`CONV_DATA_W-1:0] src_mem [1024];
    logic [`CONV_DATA_W-1:0] dst_mem [1024];
    logic [`CONV_DATA_W-1:0] wbeat_q [$];
    logic                    wlast_q [$];
    int                      r_off_q [$];
    int                      r_len_q [$];
    int                      w_off_q [$];
    int                      w_len_q [$];
    plan_t                   exp_plan;
    logic [63:0]             src_base;
    logic [63:0]             dst_base;
    logic [15:0]             bus_lfsr;
    logic [15:0]             fill_lfsr;
    logic                    coin;
    logic                    coin2;
    logic                    r_taken;
    int                      ar_pages;
    int                      aw_pages;
    int                      rd_out;
    int                      wr_out;
    int                      r_pos;
    int                      w_pos;
    int                      w_idx;
    int                      wr_done;
    int                      errors;

    conv_dma_top conv_dma_top_i (
        .clk        (clk),
        .rst        (rst),
        .ar_req     (ar_req),
        .arready    (arready),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .aw_req     (aw_req),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready),
        .reg_req    (reg_req),
        .resp_valid (resp_valid),
        .resp_data  (resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 16 bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(inout logic [15:0] state, output logic b);
        b = state[0];
        state = lfsr_step(state);
    endtask

    function automatic plan_t ref_plan(input int side);
        plan_t p;
        p.total_beats = 32'((side / `CONV_BEAT_BYTES) * side);
        p.pages       = p.total_beats / 32'(BPP);
        if (p.total_beats % 32'(BPP) != 32'd0) begin
            p.pages = p.pages + 32'd1;
        end
        // the last page carries what the full pages before it leave
        p.last_beats  = p.total_beats - (p.pages - 32'd1) * 32'(BPP);
        return p;
    endfunction

    function automatic logic [`CONV_DATA_W-1:0] ref_data(input int n);
        return src_mem[n];
    endfunction

    function automatic int page_len(input int k);
        return (k == int'(exp_plan.pages) - 1) ? int'(exp_plan.last_beats) : BPP;
    endfunction

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [`CONV_DATA_W-1:0] got,
                         input logic [`CONV_DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
            stop_run();
        end
    endtask

    // samples every handshake at the falling edge, where all signals are settled
    always @(negedge clk) begin
        r_taken = rvalid && rready;
        if (!rst) begin
            check("bready", 512'(bready), 512'(1));
            if (rvalid && rready) begin
                r_pos++;
                if (rlast) begin
                    rd_out--;
                end
                if (r_pos == r_len_q[0]) begin
                    r_off_q.pop_front();
                    r_len_q.pop_front();
                    r_pos = 0;
                end
            end
            if (ar_req.valid && arready) begin
                check("ar_addr", 512'(ar_req.addr), 512'(src_base + 64'(ar_pages) * 64'd4096));
                check("ar_len", 512'(ar_req.len), 512'(page_len(ar_pages) - 1));
                check("ar_size", 512'(ar_req.size), 512'(6));
                r_off_q.push_back(int'((ar_req.addr - src_base) / 64'd64));
                r_len_q.push_back(int'(ar_req.len) + 1);
                ar_pages++;
                rd_out++;
            end
            if (aw_req.valid && awready) begin
                check("aw_addr", 512'(aw_req.addr), 512'(dst_base + 64'(aw_pages) * 64'd4096));
                check("aw_len", 512'(aw_req.len), 512'(page_len(aw_pages) - 1));
                check("aw_size", 512'(aw_req.size), 512'(6));
                w_off_q.push_back(int'((aw_req.addr - dst_base) / 64'd64));
                w_len_q.push_back(int'(aw_req.len) + 1);
                aw_pages++;
                wr_out++;
            end
            if (wvalid && wready) begin
                check("wstrb", 512'(wstrb), 512'({`CONV_BEAT_BYTES{1'b1}}));
                wbeat_q.push_back(wdata);
                wlast_q.push_back(wlast);
                if (wlast) begin
                    wr_out--;
                end
            end
            if (rd_out > `CONV_START_CREDS || wr_out > `CONV_START_CREDS) begin
                $display("more pages outstanding than the engine has credits for");
                stop_run();
            end
            // write beats may arrive ahead of their burst address
            while (w_len_q.size() > 0 && wbeat_q.size() > 0) begin
                w_idx = w_off_q[0] + w_pos;
                check("wlast", 512'(wlast_q[0]), 512'(w_pos == w_len_q[0] - 1));
                check("wdata", wbeat_q[0], ref_data(w_idx));
                dst_mem[w_idx] = wbeat_q.pop_front();
                wlast_q.pop_front();
                w_pos++;
                wr_done++;
                if (w_pos == w_len_q[0]) begin
                    w_off_q.pop_front();
                    w_len_q.pop_front();
                    w_pos = 0;
                end
            end
        end
    end

    // throttled slave side, inputs change shortly after the rising edge
    always @(posedge clk) begin
        #1;
        take_bit(bus_lfsr, coin);
        arready = coin;
        take_bit(bus_lfsr, coin);
        awready = coin;
        take_bit(bus_lfsr, coin);
        take_bit(bus_lfsr, coin2);
        wready = coin | coin2;
        if (!rvalid || r_taken) begin
            take_bit(bus_lfsr, coin);
            if (r_len_q.size() > 0 && coin) begin
                rvalid = 1'b1;
                rdata  = src_mem[r_off_q[0] + r_pos];
                rlast  = r_pos == r_len_q[0] - 1;
            end else begin
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

    task automatic reg_write(input logic [31:0] addr, input logic [63:0] data);
        reg_req.valid    = 1'b1;
        reg_req.is_write = 1'b1;
        reg_req.addr     = addr;
        reg_req.data     = data;
        @(posedge clk);
        #1;
        reg_req.valid = 1'b0;
    endtask

    // answer must show up exactly one cycle after the strobe
    task automatic reg_read(input logic [31:0] addr, input string name,
                            input logic [63:0] exp);
        reg_req.valid    = 1'b1;
        reg_req.is_write = 1'b0;
        reg_req.addr     = addr;
        reg_req.data     = '0;
        check("resp_valid", 512'(resp_valid), 512'(0));
        @(posedge clk);
        #1;
        reg_req.valid = 1'b0;
        check("resp_valid", 512'(resp_valid), 512'(1));
        check(name, 512'(resp_data), 512'(exp));
        @(posedge clk);
        #1;
        check("resp_valid", 512'(resp_valid), 512'(0));
    endtask

    task automatic expect_quiet(input int cycles, input logic check_data);
        repeat (cycles) begin
            @(negedge clk);
            check("ar_valid", 512'(ar_req.valid), 512'(0));
            check("aw_valid", 512'(aw_req.valid), 512'(0));
            if (check_data) begin
                check("wvalid", 512'(wvalid), 512'(0));
                check("rready", 512'(rready), 512'(0));
                check("resp_valid", 512'(resp_valid), 512'(0));
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic fill_src(input int beats);
        logic b;
        for (int i = 0; i < beats; i++) begin
            for (int j = 0; j < `CONV_DATA_W; j++) begin
                take_bit(fill_lfsr, b);
                src_mem[i][j] = b;
            end
            dst_mem[i] = '0;
        end
    endtask

    task automatic run_image(input int side, input logic [63:0] src, input logic [63:0] dst);
        int cycles;
        exp_plan = ref_plan(side);
        src_base = src;
        dst_base = dst;
        ar_pages = 0;
        aw_pages = 0;
        wr_done  = 0;
        fill_src(int'(exp_plan.total_beats));
        reg_write(`CONV_REG_SRC, src);
        reg_write(`CONV_REG_DST, dst);
        reg_write(`CONV_REG_SIZE, 64'(side));
        // planner needs three cycles
        repeat (4) @(posedge clk);
        #1;
        reg_write(`CONV_REG_START, 64'd1);
        cycles = 0;
        while (wr_done < int'(exp_plan.total_beats)) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 50000) begin
                $display("timeout waiting for all write beats of side %0d", side);
                stop_run();
            end
        end
        repeat (3) @(posedge clk);
        #1;
        reg_read(`CONV_REG_STATE, "state", 64'(IDLE));
        reg_read(`CONV_REG_PAGES, "pages", 64'(exp_plan.pages));
        reg_read(`CONV_REG_RD_BEATS, "rd_beats", 64'd0);
        reg_read(`CONV_REG_WR_BEATS, "wr_beats", 64'd0);
        check("ar_pages", 512'(ar_pages), 512'(exp_plan.pages));
        check("aw_pages", 512'(aw_pages), 512'(exp_plan.pages));
        check("rd_out", 512'(rd_out), 512'(0));
        check("wr_out", 512'(wr_out), 512'(0));
        check("w_pending", 512'(wbeat_q.size() + w_len_q.size()), 512'(0));
        for (int i = 0; i < int'(exp_plan.total_beats); i++) begin
            check("dst_mem", dst_mem[i], ref_data(i));
        end
    endtask

    initial begin
        rst      = 1'b1;
        arready  = 1'b0;
        awready  = 1'b0;
        rdata    = '0;
        rlast    = 1'b0;
        rvalid   = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        bresp    = 2'b00;
        reg_req  = '0;
        bus_lfsr  = 16'd64987;
        fill_lfsr = 16'd64987;
        r_taken  = 1'b0;
        rd_out   = 0;
        wr_out   = 0;
        r_pos    = 0;
        w_pos    = 0;
        errors   = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        expect_quiet(10, 1'b1);

        run_image(64, 64'h0000_0000_1000_0000, 64'h0000_0000_8000_0000);

        // a plan is still loaded, yet out of order writes must leave the engine idle
        reg_write(`CONV_REG_DST, 64'h4000_0000);
        reg_write(`CONV_REG_START, 64'd1);
        expect_quiet(20, 1'b0);
        reg_read(`CONV_REG_STATE, "state", 64'(IDLE));

        run_image(128, 64'h0000_0001_2340_0000, 64'h0000_0002_0000_0000);
        run_image(192, 64'h0000_0000_0004_0000, 64'h0000_0000_0100_0000);
        // side 96 gives a short last page
        run_image(96, 64'h0000_0000_2000_0000, 64'h0000_0000_3000_0000);

        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

//--- sources.f
+incdir+include
rtl/conv_dma_pkg.sv
rtl/csr_decode.sv
rtl/page_planner.sv
rtl/page_req_gen.sv
rtl/stream_buffer.sv
rtl/conv_dma_top.sv
dv/tb_conv_dma.sv

//--- Makefile
TOOL      := verilator
FLAGS     := --timing --assert
SIM_FLAGS := $(FLAGS) --binary -Wno-fatal
TOP       := tb_conv_dma
FLIST     := sources.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST) | grep -v '^+')
	$(TOOL) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# exit status of the binary is the test verdict
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
